// ==== verilog/core_cfg_pkg.sv ====
package core_cfg_pkg;

	// Integer datapath width
	localparam int XLEN = 64;

	// Architectural integer registers x0..x31
	localparam int ARCH_REG_BITS = 5;

	// Rename copies per architectural register, log2
	localparam int RN_BITS = 2;

	// Physical tag is arch index plus rename copy
	localparam int PREG_BITS = ARCH_REG_BITS + RN_BITS;
	localparam int PREG_NUM = 1 << PREG_BITS;

	// Load issue buffer sizing
	localparam int LU_DEPTH = 4;
	localparam int LU_IDX_BITS = 2;

	// Store issue FIFO sizing
	localparam int SU_DEPTH = 4;
	localparam int SU_IDX_BITS = 2;

endpackage

// ==== verilog/lsu_pkg.sv ====
package lsu_pkg;

	// Opcode field widths
	localparam int LU_OP_W = 3;
	localparam int SU_OP_W = 2;
	localparam int IMM_W = core_cfg_pkg::XLEN;

	// Load opcodes, unsigned variants last
	typedef enum logic [LU_OP_W-1:0] {
		LB,
		LH,
		LW,
		LD,
		LBU,
		LHU,
		LWU
	} lu_op_e;

	// Store opcodes
	typedef enum logic [SU_OP_W-1:0] {
		SB,
		SH,
		SW,
		SD
	} su_op_e;

	// Access size handed to the load unit
	typedef enum logic [1:0] {
		BYTE,
		HALF,
		WORD,
		DOUBLE
	} lu_width_e;

	// Load info layout, MSB first: op, imm, rd, rs1
	localparam int LU_RS1_LSB = 0;
	localparam int LU_RD_LSB = LU_RS1_LSB + core_cfg_pkg::PREG_BITS;
	localparam int LU_IMM_LSB = LU_RD_LSB + core_cfg_pkg::PREG_BITS;
	localparam int LU_OP_LSB = LU_IMM_LSB + IMM_W;
	localparam int LU_INFO_W = LU_OP_LSB + LU_OP_W;

	// Store info layout, MSB first: op, imm, rs1, rs2
	localparam int SU_RS2_LSB = 0;
	localparam int SU_RS1_LSB = SU_RS2_LSB + core_cfg_pkg::PREG_BITS;
	localparam int SU_IMM_LSB = SU_RS1_LSB + core_cfg_pkg::PREG_BITS;
	localparam int SU_OP_LSB = SU_IMM_LSB + IMM_W;
	localparam int SU_INFO_W = SU_OP_LSB + SU_OP_W;

endpackage

// ==== verilog/phy_regfile.sv ====
`timescale 1ns/10ps

module phy_regfile (
	input logic CLK,
	input logic rst_n,

	// Rename allocation of a new producer
	input logic preg_alloc,
	input logic [core_cfg_pkg::PREG_BITS-1:0] preg_alloc_tag,

	// Result writeback
	input logic wb_valid,
	input logic [core_cfg_pkg::PREG_BITS-1:0] wb_tag,
	input logic [core_cfg_pkg::XLEN-1:0] wb_data,

	// Every register visible at once
	output logic [core_cfg_pkg::PREG_NUM*core_cfg_pkg::XLEN-1:0] rd_data_flat,
	output logic [core_cfg_pkg::PREG_NUM-1:0] wb_log
);

	logic [core_cfg_pkg::XLEN-1:0] regs_q [core_cfg_pkg::PREG_NUM];

	// Data array, cleared at reset
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < core_cfg_pkg::PREG_NUM; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wb_valid) begin
			regs_q[wb_tag] <= wb_data;
		end
	end

	// Written-back bits
	// Everything counts as written back out of reset
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wb_log <= '1;
		end else begin
			// Producer renamed onto the tag
			if (preg_alloc) begin
				wb_log[preg_alloc_tag] <= 1'b0;
			end
			// Later assignment, so writeback wins on a tag clash
			if (wb_valid) begin
				wb_log[wb_tag] <= 1'b1;
			end
		end
	end

	// Flatten for the issue logic
	for (genvar i = 0; i < core_cfg_pkg::PREG_NUM; i++) begin : g_flat
		assign rd_data_flat[i*core_cfg_pkg::XLEN +: core_cfg_pkg::XLEN] = regs_q[i];
	end

endmodule

// ==== verilog/lu_issue_buffer.sv ====
`timescale 1ns/10ps

module lu_issue_buffer (
	input logic CLK,
	input logic rst_n,

	// Dispatch strobe
	input logic lu_dispatch,
	input lsu_pkg::lu_op_e lu_op,
	input logic [core_cfg_pkg::XLEN-1:0] lu_imm,
	input logic [core_cfg_pkg::PREG_BITS-1:0] lu_rd,
	input logic [core_cfg_pkg::PREG_BITS-1:0] lu_rs1,

	// Removal of an issued entry
	input logic lu_pop,
	input logic [core_cfg_pkg::LU_IDX_BITS-1:0] lu_pop_index,

	// Slot occupancy and contents
	output logic [core_cfg_pkg::LU_DEPTH-1:0] lu_malloc,
	output logic [core_cfg_pkg::LU_DEPTH*lsu_pkg::LU_INFO_W-1:0] lu_info_flat,
	output logic lu_full
);

	logic [lsu_pkg::LU_INFO_W-1:0] info_q [core_cfg_pkg::LU_DEPTH];
	logic [core_cfg_pkg::LU_IDX_BITS-1:0] free_idx;

	assign lu_full = &lu_malloc;

	// Lowest free slot
	// Scan downward so the smallest index is written last
	always_comb begin
		free_idx = '0;
		for (int i = core_cfg_pkg::LU_DEPTH - 1; i >= 0; i--) begin
			if (!lu_malloc[i]) begin
				free_idx = i[core_cfg_pkg::LU_IDX_BITS-1:0];
			end
		end
	end

	// Occupied bits
	// Pop and dispatch never share a slot, popped one is occupied
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			lu_malloc <= '0;
		end else begin
			if (lu_pop) begin
				lu_malloc[lu_pop_index] <= 1'b0;
			end
			if (lu_dispatch) begin
				lu_malloc[free_idx] <= 1'b1;
			end
		end
	end

	// Load info payload
	always_ff @(posedge CLK) begin
		if (lu_dispatch) begin
			info_q[free_idx] <= {lu_op, lu_imm, lu_rd, lu_rs1};
		end
	end

	for (genvar i = 0; i < core_cfg_pkg::LU_DEPTH; i++) begin : g_flat
		assign lu_info_flat[i*lsu_pkg::LU_INFO_W +: lsu_pkg::LU_INFO_W] = info_q[i];
	end

	// Dispatch side must respect lu_full
	a_no_dispatch_full: assert property (
		@(posedge CLK) disable iff (!rst_n) lu_dispatch |-> !lu_full
	);

	// Issue logic only pops live slots
	a_no_pop_empty: assert property (
		@(posedge CLK) disable iff (!rst_n) lu_pop |-> lu_malloc[lu_pop_index]
	);

endmodule

// ==== verilog/su_issue_fifo.sv ====
`timescale 1ns/10ps

module su_issue_fifo (
	input logic CLK,
	input logic rst_n,

	// Dispatch strobe
	input logic su_dispatch,
	input lsu_pkg::su_op_e su_op,
	input logic [core_cfg_pkg::XLEN-1:0] su_imm,
	input logic [core_cfg_pkg::PREG_BITS-1:0] su_rs1,
	input logic [core_cfg_pkg::PREG_BITS-1:0] su_rs2,

	input logic su_pop,

	output logic su_empty,
	output logic su_full,
	output logic [lsu_pkg::SU_INFO_W-1:0] su_head_info
);

	logic [lsu_pkg::SU_INFO_W-1:0] fifo_q [core_cfg_pkg::SU_DEPTH];
	logic [core_cfg_pkg::SU_IDX_BITS-1:0] wr_ptr;
	logic [core_cfg_pkg::SU_IDX_BITS-1:0] rd_ptr;
	logic [core_cfg_pkg::SU_IDX_BITS:0] count;

	assign su_empty = (count == '0);
	assign su_full = (count == core_cfg_pkg::SU_DEPTH);
	// Oldest store in program order
	assign su_head_info = fifo_q[rd_ptr];

	// Pointers wrap naturally, depth is a power of two
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (su_dispatch) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (su_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({su_dispatch, su_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Store info payload
	always_ff @(posedge CLK) begin
		if (su_dispatch) begin
			fifo_q[wr_ptr] <= {su_op, su_imm, su_rs1, su_rs2};
		end
	end

	a_no_push_full: assert property (
		@(posedge CLK) disable iff (!rst_n) su_dispatch |-> !su_full
	);

	a_no_pop_empty: assert property (
		@(posedge CLK) disable iff (!rst_n) su_pop |-> !su_empty
	);

endmodule

// ==== verilog/lsu_issue.sv ====
`timescale 1ns/10ps

module lsu_issue (
	input logic CLK,
	input logic rst_n,

	// Load buffer view
	input logic [core_cfg_pkg::LU_DEPTH-1:0] lu_malloc,
	input logic [core_cfg_pkg::LU_DEPTH*lsu_pkg::LU_INFO_W-1:0] lu_info_flat,
	output logic lu_pop,
	output logic [core_cfg_pkg::LU_IDX_BITS-1:0] lu_pop_index,

	// Load execute packet
	input logic lu_exe_ready,
	output logic lu_exe_valid,
	output lsu_pkg::lu_width_e lu_exe_width,
	output logic lu_exe_unsigned,
	output logic [core_cfg_pkg::PREG_BITS-1:0] lu_exe_rd,
	output logic [core_cfg_pkg::XLEN-1:0] lu_exe_addr,

	// Store FIFO head
	input logic su_empty,
	input logic [lsu_pkg::SU_INFO_W-1:0] su_head_info,
	output logic su_pop,

	// No older instruction can still be cancelled
	input logic su_commit_ready,

	// Store execute packet
	input logic su_exe_ready,
	output logic su_exe_valid,
	output lsu_pkg::su_op_e su_exe_op,
	output logic [core_cfg_pkg::XLEN-1:0] su_exe_addr,
	output logic [core_cfg_pkg::XLEN-1:0] su_exe_data,

	// Register file
	input logic [core_cfg_pkg::PREG_NUM*core_cfg_pkg::XLEN-1:0] rd_data_flat,
	input logic [core_cfg_pkg::PREG_NUM-1:0] wb_log
);

	localparam int LW_ = lsu_pkg::LU_INFO_W;
	localparam int XL = core_cfg_pkg::XLEN;

	lsu_pkg::lu_op_e lu_slot_op [core_cfg_pkg::LU_DEPTH];
	logic [XL-1:0] lu_slot_imm [core_cfg_pkg::LU_DEPTH];
	logic [core_cfg_pkg::PREG_BITS-1:0] lu_slot_rd [core_cfg_pkg::LU_DEPTH];
	logic [core_cfg_pkg::PREG_BITS-1:0] lu_slot_rs1 [core_cfg_pkg::LU_DEPTH];
	logic [XL-1:0] lu_slot_addr [core_cfg_pkg::LU_DEPTH];
	logic [core_cfg_pkg::LU_DEPTH-1:0] lu_slot_ready;
	logic lu_pick_valid;
	logic [core_cfg_pkg::LU_IDX_BITS-1:0] lu_pick_idx;
	lsu_pkg::lu_width_e lu_pick_width;
	logic lu_pick_unsigned;

	lsu_pkg::su_op_e su_head_op;
	logic [XL-1:0] su_head_imm;
	logic [core_cfg_pkg::PREG_BITS-1:0] su_head_rs1;
	logic [core_cfg_pkg::PREG_BITS-1:0] su_head_rs2;
	logic su_can_issue;

	// Per-slot unpack, rs1 readiness and address
	always_comb begin
		for (int i = 0; i < core_cfg_pkg::LU_DEPTH; i++) begin
			lu_slot_op[i] = lsu_pkg::lu_op_e'(
				lu_info_flat[i*LW_ + lsu_pkg::LU_OP_LSB +: lsu_pkg::LU_OP_W]);
			lu_slot_imm[i] = lu_info_flat[i*LW_ + lsu_pkg::LU_IMM_LSB +: XL];
			lu_slot_rd[i] = lu_info_flat[i*LW_ + lsu_pkg::LU_RD_LSB +: core_cfg_pkg::PREG_BITS];
			lu_slot_rs1[i] = lu_info_flat[i*LW_ + lsu_pkg::LU_RS1_LSB +: core_cfg_pkg::PREG_BITS];
			// Only live slots whose base has been written back
			lu_slot_ready[i] = lu_malloc[i] & wb_log[lu_slot_rs1[i]];
			lu_slot_addr[i] = rd_data_flat[lu_slot_rs1[i]*XL +: XL] + lu_slot_imm[i];
		end
	end

	// Lowest ready index wins
	always_comb begin
		lu_pick_valid = 1'b0;
		lu_pick_idx = '0;
		for (int i = core_cfg_pkg::LU_DEPTH - 1; i >= 0; i--) begin
			if (lu_slot_ready[i]) begin
				lu_pick_valid = 1'b1;
				lu_pick_idx = i[core_cfg_pkg::LU_IDX_BITS-1:0];
			end
		end
	end

	// Opcode to access size and sign handling
	always_comb begin
		case (lu_slot_op[lu_pick_idx])
			lsu_pkg::LB, lsu_pkg::LBU: lu_pick_width = lsu_pkg::BYTE;
			lsu_pkg::LH, lsu_pkg::LHU: lu_pick_width = lsu_pkg::HALF;
			lsu_pkg::LW, lsu_pkg::LWU: lu_pick_width = lsu_pkg::WORD;
			default: lu_pick_width = lsu_pkg::DOUBLE;
		endcase
		lu_pick_unsigned = (lu_slot_op[lu_pick_idx] == lsu_pkg::LBU) |
			(lu_slot_op[lu_pick_idx] == lsu_pkg::LHU) |
			(lu_slot_op[lu_pick_idx] == lsu_pkg::LWU);
	end

	// Pop only when the output register takes a new packet
	assign lu_pop = lu_exe_ready & lu_pick_valid;
	assign lu_pop_index = lu_pick_idx;

	// Valid holds under back-pressure
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			lu_exe_valid <= 1'b0;
		end else if (lu_exe_ready) begin
			lu_exe_valid <= lu_pick_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (lu_pop) begin
			lu_exe_width <= lu_pick_width;
			lu_exe_unsigned <= lu_pick_unsigned;
			lu_exe_rd <= lu_slot_rd[lu_pick_idx];
			lu_exe_addr <= lu_slot_addr[lu_pick_idx];
		end
	end

	// Store head unpack
	assign su_head_op = lsu_pkg::su_op_e'(
		su_head_info[lsu_pkg::SU_OP_LSB +: lsu_pkg::SU_OP_W]);
	assign su_head_imm = su_head_info[lsu_pkg::SU_IMM_LSB +: XL];
	assign su_head_rs1 = su_head_info[lsu_pkg::SU_RS1_LSB +: core_cfg_pkg::PREG_BITS];
	assign su_head_rs2 = su_head_info[lsu_pkg::SU_RS2_LSB +: core_cfg_pkg::PREG_BITS];

	// Both operands back and nothing older can be cancelled
	assign su_can_issue = ~su_empty & wb_log[su_head_rs1] & wb_log[su_head_rs2] &
		su_commit_ready;
	assign su_pop = su_exe_ready & su_can_issue;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			su_exe_valid <= 1'b0;
		end else if (su_exe_ready) begin
			su_exe_valid <= su_can_issue;
		end
	end

	always_ff @(posedge CLK) begin
		if (su_pop) begin
			su_exe_op <= su_head_op;
			su_exe_addr <= rd_data_flat[su_head_rs1*XL +: XL] + su_head_imm;
			su_exe_data <= rd_data_flat[su_head_rs2*XL +: XL];
		end
	end

	// Stalled packets stay put until taken
	a_lu_hold: assert property (
		@(posedge CLK) disable iff (!rst_n)
		lu_exe_valid && !lu_exe_ready |=> lu_exe_valid &&
			$stable({lu_exe_width, lu_exe_unsigned, lu_exe_rd, lu_exe_addr})
	);

	a_su_hold: assert property (
		@(posedge CLK) disable iff (!rst_n)
		su_exe_valid && !su_exe_ready |=> su_exe_valid &&
			$stable({su_exe_op, su_exe_addr, su_exe_data})
	);

endmodule

// ==== verilog/lsu_issue_top.sv ====
`timescale 1ns/10ps

module lsu_issue_top (
	input logic CLK,
	input logic rst_n,

	// Load dispatch
	input logic lu_dispatch,
	input lsu_pkg::lu_op_e lu_op,
	input logic [core_cfg_pkg::XLEN-1:0] lu_imm,
	input logic [core_cfg_pkg::PREG_BITS-1:0] lu_rd,
	input logic [core_cfg_pkg::PREG_BITS-1:0] lu_rs1,
	output logic lu_full,

	// Store dispatch
	input logic su_dispatch,
	input lsu_pkg::su_op_e su_op,
	input logic [core_cfg_pkg::XLEN-1:0] su_imm,
	input logic [core_cfg_pkg::PREG_BITS-1:0] su_rs1,
	input logic [core_cfg_pkg::PREG_BITS-1:0] su_rs2,
	output logic su_full,

	// Rename and writeback
	input logic preg_alloc,
	input logic [core_cfg_pkg::PREG_BITS-1:0] preg_alloc_tag,
	input logic wb_valid,
	input logic [core_cfg_pkg::PREG_BITS-1:0] wb_tag,
	input logic [core_cfg_pkg::XLEN-1:0] wb_data,

	input logic su_commit_ready,

	// Load execute
	input logic lu_exe_ready,
	output logic lu_exe_valid,
	output lsu_pkg::lu_width_e lu_exe_width,
	output logic lu_exe_unsigned,
	output logic [core_cfg_pkg::PREG_BITS-1:0] lu_exe_rd,
	output logic [core_cfg_pkg::XLEN-1:0] lu_exe_addr,

	// Store execute
	input logic su_exe_ready,
	output logic su_exe_valid,
	output lsu_pkg::su_op_e su_exe_op,
	output logic [core_cfg_pkg::XLEN-1:0] su_exe_addr,
	output logic [core_cfg_pkg::XLEN-1:0] su_exe_data
);

	logic [core_cfg_pkg::PREG_NUM*core_cfg_pkg::XLEN-1:0] rd_data_flat;
	logic [core_cfg_pkg::PREG_NUM-1:0] wb_log;
	logic [core_cfg_pkg::LU_DEPTH-1:0] lu_malloc;
	logic [core_cfg_pkg::LU_DEPTH*lsu_pkg::LU_INFO_W-1:0] lu_info_flat;
	logic lu_pop;
	logic [core_cfg_pkg::LU_IDX_BITS-1:0] lu_pop_index;
	logic su_empty;
	logic su_pop;
	logic [lsu_pkg::SU_INFO_W-1:0] su_head_info;

	phy_regfile phy_regfile_inst (
		.CLK(CLK),
		.rst_n(rst_n),
		.preg_alloc(preg_alloc),
		.preg_alloc_tag(preg_alloc_tag),
		.wb_valid(wb_valid),
		.wb_tag(wb_tag),
		.wb_data(wb_data),
		.rd_data_flat(rd_data_flat),
		.wb_log(wb_log)
	);

	lu_issue_buffer lu_issue_buffer_inst (
		.CLK(CLK),
		.rst_n(rst_n),
		.lu_dispatch(lu_dispatch),
		.lu_op(lu_op),
		.lu_imm(lu_imm),
		.lu_rd(lu_rd),
		.lu_rs1(lu_rs1),
		.lu_pop(lu_pop),
		.lu_pop_index(lu_pop_index),
		.lu_malloc(lu_malloc),
		.lu_info_flat(lu_info_flat),
		.lu_full(lu_full)
	);

	su_issue_fifo su_issue_fifo_inst (
		.CLK(CLK),
		.rst_n(rst_n),
		.su_dispatch(su_dispatch),
		.su_op(su_op),
		.su_imm(su_imm),
		.su_rs1(su_rs1),
		.su_rs2(su_rs2),
		.su_pop(su_pop),
		.su_empty(su_empty),
		.su_full(su_full),
		.su_head_info(su_head_info)
	);

	lsu_issue lsu_issue_inst (
		.CLK(CLK),
		.rst_n(rst_n),
		.lu_malloc(lu_malloc),
		.lu_info_flat(lu_info_flat),
		.lu_pop(lu_pop),
		.lu_pop_index(lu_pop_index),
		.lu_exe_ready(lu_exe_ready),
		.lu_exe_valid(lu_exe_valid),
		.lu_exe_width(lu_exe_width),
		.lu_exe_unsigned(lu_exe_unsigned),
		.lu_exe_rd(lu_exe_rd),
		.lu_exe_addr(lu_exe_addr),
		.su_empty(su_empty),
		.su_head_info(su_head_info),
		.su_pop(su_pop),
		.su_commit_ready(su_commit_ready),
		.su_exe_ready(su_exe_ready),
		.su_exe_valid(su_exe_valid),
		.su_exe_op(su_exe_op),
		.su_exe_addr(su_exe_addr),
		.su_exe_data(su_exe_data),
		.rd_data_flat(rd_data_flat),
		.wb_log(wb_log)
	);

	// Rename must not reuse a tag a waiting load still reads
	// A slot popped this cycle has already read its base
	for (genvar i = 0; i < core_cfg_pkg::LU_DEPTH; i++) begin : g_alloc_chk
		logic [core_cfg_pkg::PREG_BITS-1:0] slot_rs1;
		assign slot_rs1 = lu_info_flat[i*lsu_pkg::LU_INFO_W + lsu_pkg::LU_RS1_LSB +:
			core_cfg_pkg::PREG_BITS];
		a_no_alloc_lu_src: assert property (
			@(posedge CLK) disable iff (!rst_n)
			preg_alloc && lu_malloc[i] && !(lu_pop && lu_pop_index == i) |->
				preg_alloc_tag != slot_rs1
		);
	end

	// Same for the oldest waiting store
	a_no_alloc_su_src: assert property (
		@(posedge CLK) disable iff (!rst_n)
		preg_alloc && !su_empty && !su_pop |->
			preg_alloc_tag != su_head_info[lsu_pkg::SU_RS1_LSB +: core_cfg_pkg::PREG_BITS] &&
			preg_alloc_tag != su_head_info[lsu_pkg::SU_RS2_LSB +: core_cfg_pkg::PREG_BITS]
	);

endmodule

// ==== dv/lsu_issue_tb.sv ====
`timescale 1ns/10ps

module lsu_issue_tb;

	// Run length bookkeeping for the watchdog
	localparam int CLK_NS = 4;
	localparam int RESET_CYCLES = 16;
	localparam int DRAIN_LIMIT = 100;
	localparam int RANDOM_CYCLES = 400;
	localparam int DIRECTED_CYCLES = 5 * (40 + DRAIN_LIMIT + 4);
	localparam int RANDOM_TOTAL = 16 + RANDOM_CYCLES + 64 + DRAIN_LIMIT + 4;
	localparam int WATCHDOG_NS =
		(RESET_CYCLES + DIRECTED_CYCLES + RANDOM_TOTAL + 100) * CLK_NS;

	localparam int PB = core_cfg_pkg::PREG_BITS;
	localparam int XL = core_cfg_pkg::XLEN;

	logic CLK;
	logic rst_n;

	// DUT inputs
	logic lu_dispatch;
	lsu_pkg::lu_op_e lu_op;
	logic [XL-1:0] lu_imm;
	logic [PB-1:0] lu_rd;
	logic [PB-1:0] lu_rs1;
	logic su_dispatch;
	lsu_pkg::su_op_e su_op;
	logic [XL-1:0] su_imm;
	logic [PB-1:0] su_rs1;
	logic [PB-1:0] su_rs2;
	logic preg_alloc;
	logic [PB-1:0] preg_alloc_tag;
	logic wb_valid;
	logic [PB-1:0] wb_tag;
	logic [XL-1:0] wb_data;
	logic su_commit_ready;
	logic lu_exe_ready;
	logic su_exe_ready;

	// DUT outputs
	logic lu_full;
	logic su_full;
	logic lu_exe_valid;
	lsu_pkg::lu_width_e lu_exe_width;
	logic lu_exe_unsigned;
	logic [PB-1:0] lu_exe_rd;
	logic [XL-1:0] lu_exe_addr;
	logic su_exe_valid;
	lsu_pkg::su_op_e su_exe_op;
	logic [XL-1:0] su_exe_addr;
	logic [XL-1:0] su_exe_data;

	// Reference model state
	logic ml_busy [core_cfg_pkg::LU_DEPTH];
	lsu_pkg::lu_op_e ml_op [core_cfg_pkg::LU_DEPTH];
	logic [XL-1:0] ml_imm [core_cfg_pkg::LU_DEPTH];
	logic [PB-1:0] ml_rd [core_cfg_pkg::LU_DEPTH];
	logic [PB-1:0] ml_rs1 [core_cfg_pkg::LU_DEPTH];
	lsu_pkg::su_op_e ms_op [$];
	logic [XL-1:0] ms_imm [$];
	logic [PB-1:0] ms_rs1 [$];
	logic [PB-1:0] ms_rs2 [$];
	logic m_wb [core_cfg_pkg::PREG_NUM];
	logic [XL-1:0] m_reg [core_cfg_pkg::PREG_NUM];

	// Predicted outputs, registered like the DUT
	logic m_lu_valid;
	lsu_pkg::lu_width_e m_lu_width;
	logic m_lu_unsigned;
	logic [PB-1:0] m_lu_rd;
	logic [XL-1:0] m_lu_addr;
	logic m_su_valid;
	lsu_pkg::su_op_e m_su_op;
	logic [XL-1:0] m_su_addr;
	logic [XL-1:0] m_su_data;
	logic m_lu_full;
	logic m_su_full;

	logic [PB+XL+2:0] lu_pkt_dut;
	logic [PB+XL+2:0] lu_pkt_ref;
	logic [2*XL+1:0] su_pkt_dut;
	logic [2*XL+1:0] su_pkt_ref;

	// Scoreboard counters
	int lu_sent;
	int su_sent;
	int lu_seen;
	int su_seen;
	int error_count;
	int errors_at_start;
	int tests_run;
	string test_name;
	integer seed;
	logic [PB-1:0] pending [$];

	lsu_issue_top lsu_issue_top_inst (
		.CLK(CLK),
		.rst_n(rst_n),
		.lu_dispatch(lu_dispatch),
		.lu_op(lu_op),
		.lu_imm(lu_imm),
		.lu_rd(lu_rd),
		.lu_rs1(lu_rs1),
		.lu_full(lu_full),
		.su_dispatch(su_dispatch),
		.su_op(su_op),
		.su_imm(su_imm),
		.su_rs1(su_rs1),
		.su_rs2(su_rs2),
		.su_full(su_full),
		.preg_alloc(preg_alloc),
		.preg_alloc_tag(preg_alloc_tag),
		.wb_valid(wb_valid),
		.wb_tag(wb_tag),
		.wb_data(wb_data),
		.su_commit_ready(su_commit_ready),
		.lu_exe_ready(lu_exe_ready),
		.lu_exe_valid(lu_exe_valid),
		.lu_exe_width(lu_exe_width),
		.lu_exe_unsigned(lu_exe_unsigned),
		.lu_exe_rd(lu_exe_rd),
		.lu_exe_addr(lu_exe_addr),
		.su_exe_ready(su_exe_ready),
		.su_exe_valid(su_exe_valid),
		.su_exe_op(su_exe_op),
		.su_exe_addr(su_exe_addr),
		.su_exe_data(su_exe_data)
	);

	// 4 ns period
	always #2 CLK = ~CLK;

	// Access size per load opcode
	function automatic lsu_pkg::lu_width_e load_width(lsu_pkg::lu_op_e op);
		case (op)
			lsu_pkg::LB, lsu_pkg::LBU: return lsu_pkg::BYTE;
			lsu_pkg::LH, lsu_pkg::LHU: return lsu_pkg::HALF;
			lsu_pkg::LW, lsu_pkg::LWU: return lsu_pkg::WORD;
			default: return lsu_pkg::DOUBLE;
		endcase
	endfunction

	// Zero-extending loads only
	function automatic logic load_unsigned(lsu_pkg::lu_op_e op);
		return op inside {lsu_pkg::LBU, lsu_pkg::LHU, lsu_pkg::LWU};
	endfunction

	// Random tag from the shared pool 32..47
	function automatic logic [PB-1:0] pool_tag();
		return PB'(32 + ($random(seed) & 15));
	endfunction

	// Tag still pending, or read by any waiting load or store
	function automatic logic tag_in_use(logic [PB-1:0] tag);
		logic hit;
		hit = 1'b0;
		foreach (pending[i]) begin
			hit |= (pending[i] == tag);
		end
		for (int i = 0; i < core_cfg_pkg::LU_DEPTH; i++) begin
			hit |= ml_busy[i] && (ml_rs1[i] == tag);
		end
		foreach (ms_rs1[i]) begin
			hit |= (ms_rs1[i] == tag) || (ms_rs2[i] == tag);
		end
		return hit;
	endfunction

	function automatic void report_mismatch(string field, logic [191:0] expected,
		logic [191:0] actual);
		error_count++;
		$display("MISMATCH %s %s expected %0h actual %0h", test_name, field, expected, actual);
	endfunction

	function automatic void flag_error(string what);
		error_count++;
		$display("ERROR %s: %s", test_name, what);
	endfunction

	// Model advances on the same edge as the DUT
	always @(posedge CLK or negedge rst_n) begin : ref_model
		int pick;
		int free_slot;
		logic st_go;
		logic all_busy;
		if (!rst_n) begin
			for (int i = 0; i < core_cfg_pkg::LU_DEPTH; i++) begin
				ml_busy[i] = 1'b0;
			end
			for (int i = 0; i < core_cfg_pkg::PREG_NUM; i++) begin
				m_wb[i] = 1'b1;
				m_reg[i] = '0;
			end
			ms_op.delete();
			ms_imm.delete();
			ms_rs1.delete();
			ms_rs2.delete();
			m_lu_valid <= 1'b0;
			m_su_valid <= 1'b0;
			m_lu_full <= 1'b0;
			m_su_full <= 1'b0;
		end else begin
			// Lowest occupied slot with its base written back
			pick = -1;
			for (int i = core_cfg_pkg::LU_DEPTH - 1; i >= 0; i--) begin
				if (ml_busy[i] && m_wb[ml_rs1[i]]) begin
					pick = i;
				end
			end
			// Lowest free slot, before this edge's pop
			free_slot = -1;
			for (int i = core_cfg_pkg::LU_DEPTH - 1; i >= 0; i--) begin
				if (!ml_busy[i]) begin
					free_slot = i;
				end
			end
			if (lu_exe_ready) begin
				m_lu_valid <= (pick >= 0);
				if (pick >= 0) begin
					m_lu_width <= load_width(ml_op[pick]);
					m_lu_unsigned <= load_unsigned(ml_op[pick]);
					m_lu_rd <= ml_rd[pick];
					m_lu_addr <= m_reg[ml_rs1[pick]] + ml_imm[pick];
					ml_busy[pick] = 1'b0;
				end
			end
			if (lu_dispatch && free_slot >= 0) begin
				ml_busy[free_slot] = 1'b1;
				ml_op[free_slot] = lu_op;
				ml_imm[free_slot] = lu_imm;
				ml_rd[free_slot] = lu_rd;
				ml_rs1[free_slot] = lu_rs1;
			end
			// Store head needs both operands and commit
			st_go = (ms_op.size() > 0) && su_commit_ready;
			if (st_go) begin
				st_go = m_wb[ms_rs1[0]] && m_wb[ms_rs2[0]];
			end
			if (su_exe_ready) begin
				m_su_valid <= st_go;
				if (st_go) begin
					m_su_op <= ms_op.pop_front();
					m_su_addr <= m_reg[ms_rs1[0]] + ms_imm.pop_front();
					m_su_data <= m_reg[ms_rs2[0]];
					void'(ms_rs1.pop_front());
					void'(ms_rs2.pop_front());
				end
			end
			if (su_dispatch) begin
				ms_op.push_back(su_op);
				ms_imm.push_back(su_imm);
				ms_rs1.push_back(su_rs1);
				ms_rs2.push_back(su_rs2);
			end
			// Writeback applied last so it wins over rename
			if (preg_alloc) begin
				m_wb[preg_alloc_tag] = 1'b0;
			end
			if (wb_valid) begin
				m_wb[wb_tag] = 1'b1;
				m_reg[wb_tag] = wb_data;
			end
			all_busy = 1'b1;
			for (int i = 0; i < core_cfg_pkg::LU_DEPTH; i++) begin
				all_busy &= ml_busy[i];
			end
			m_lu_full <= all_busy;
			m_su_full <= (ms_op.size() == core_cfg_pkg::SU_DEPTH);
		end
	end

	// Accepted handshakes
	always @(posedge CLK) begin
		if (rst_n && lu_exe_valid && lu_exe_ready) begin
			lu_seen++;
		end
		if (rst_n && su_exe_valid && su_exe_ready) begin
			su_seen++;
		end
	end

	assign lu_pkt_dut = {lu_exe_width, lu_exe_unsigned, lu_exe_rd, lu_exe_addr};
	assign lu_pkt_ref = {m_lu_width, m_lu_unsigned, m_lu_rd, m_lu_addr};
	assign su_pkt_dut = {su_exe_op, su_exe_addr, su_exe_data};
	assign su_pkt_ref = {m_su_op, m_su_addr, m_su_data};

	// Cycle-exact comparison against the model
	a_lu_valid: assert property (@(posedge CLK) disable iff (!rst_n)
		lu_exe_valid == m_lu_valid)
		else report_mismatch("lu_exe_valid", 192'($sampled(m_lu_valid)),
			192'($sampled(lu_exe_valid)));

	// Packet held while stalled is covered here too
	a_lu_pkt: assert property (@(posedge CLK) disable iff (!rst_n)
		lu_exe_valid |-> lu_pkt_dut == lu_pkt_ref)
		else report_mismatch("load packet", 192'($sampled(lu_pkt_ref)),
			192'($sampled(lu_pkt_dut)));

	a_su_valid: assert property (@(posedge CLK) disable iff (!rst_n)
		su_exe_valid == m_su_valid)
		else report_mismatch("su_exe_valid", 192'($sampled(m_su_valid)),
			192'($sampled(su_exe_valid)));

	a_su_pkt: assert property (@(posedge CLK) disable iff (!rst_n)
		su_exe_valid |-> su_pkt_dut == su_pkt_ref)
		else report_mismatch("store packet", 192'($sampled(su_pkt_ref)),
			192'($sampled(su_pkt_dut)));

	a_lu_full: assert property (@(posedge CLK) disable iff (!rst_n) lu_full == m_lu_full)
		else report_mismatch("lu_full", 192'($sampled(m_lu_full)), 192'($sampled(lu_full)));

	a_su_full: assert property (@(posedge CLK) disable iff (!rst_n) su_full == m_su_full)
		else report_mismatch("su_full", 192'($sampled(m_su_full)), 192'($sampled(su_full)));

	// Strobes last exactly one cycle
	task automatic next_cycle();
		@(negedge CLK);
		lu_dispatch = 1'b0;
		su_dispatch = 1'b0;
		preg_alloc = 1'b0;
		wb_valid = 1'b0;
	endtask

	task automatic dispatch_load(lsu_pkg::lu_op_e op, logic [XL-1:0] imm, logic [PB-1:0] rd,
		logic [PB-1:0] rs1);
		while (lu_full) begin
			next_cycle();
		end
		lu_dispatch = 1'b1;
		lu_op = op;
		lu_imm = imm;
		lu_rd = rd;
		lu_rs1 = rs1;
		lu_sent++;
	endtask

	task automatic dispatch_store(lsu_pkg::su_op_e op, logic [XL-1:0] imm,
		logic [PB-1:0] rs1, logic [PB-1:0] rs2);
		while (su_full) begin
			next_cycle();
		end
		su_dispatch = 1'b1;
		su_op = op;
		su_imm = imm;
		su_rs1 = rs1;
		su_rs2 = rs2;
		su_sent++;
	endtask

	task automatic allocate_tag(logic [PB-1:0] tag);
		preg_alloc = 1'b1;
		preg_alloc_tag = tag;
	endtask

	task automatic write_back(logic [PB-1:0] tag, logic [XL-1:0] data);
		wb_valid = 1'b1;
		wb_tag = tag;
		wb_data = data;
	endtask

	// Open the stage fully and wait for every entry to leave
	task automatic drain_all();
		int waited;
		waited = 0;
		lu_exe_ready = 1'b1;
		su_exe_ready = 1'b1;
		su_commit_ready = 1'b1;
		while ((lu_seen != lu_sent || su_seen != su_sent) && waited < DRAIN_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (lu_seen != lu_sent || su_seen != su_sent) begin
			flag_error("drain timed out with loads or stores still waiting");
		end
		// Nothing extra may leave afterwards
		repeat (4) next_cycle();
		a_counts: assert (lu_seen == lu_sent && su_seen == su_sent)
			else flag_error("issued count differs from dispatched count");
	endtask

	task automatic start_test(string name);
		test_name = name;
		errors_at_start = error_count;
	endtask

	task automatic end_test();
		tests_run++;
		$display("Test %s done, %0d errors", test_name, error_count - errors_at_start);
	endtask

	initial begin
		int idx;
		logic [PB-1:0] tag;
		seed = 84;
		CLK = 1'b0;
		rst_n = 1'b0;
		lu_dispatch = 1'b0;
		lu_op = lsu_pkg::LB;
		lu_imm = '0;
		lu_rd = '0;
		lu_rs1 = '0;
		su_dispatch = 1'b0;
		su_op = lsu_pkg::SB;
		su_imm = '0;
		su_rs1 = '0;
		su_rs2 = '0;
		preg_alloc = 1'b0;
		preg_alloc_tag = '0;
		wb_valid = 1'b0;
		wb_tag = '0;
		wb_data = '0;
		su_commit_ready = 1'b1;
		lu_exe_ready = 1'b1;
		su_exe_ready = 1'b1;
		repeat (RESET_CYCLES) @(negedge CLK);
		rst_n = 1'b1;

		// Every load opcode on ready bases
		start_test("basic_load");
		write_back(10, 64'h0000_0000_0000_1000);
		next_cycle();
		write_back(11, 64'h8000_0000_0000_0004);
		next_cycle();
		write_back(12, 64'hdead_beef_0000_1111);
		next_cycle();
		for (int i = 0; i < 7; i++) begin
			dispatch_load(lsu_pkg::lu_op_e'(3'(i)), {$random(seed), $random(seed)},
				PB'(20 + i), PB'(10 + (i % 3)));
			next_cycle();
		end
		drain_all();
		end_test();

		// Later dispatch in slot 0 beats older slot 1
		start_test("out_of_order");
		allocate_tag(30);
		next_cycle();
		allocate_tag(31);
		next_cycle();
		dispatch_load(lsu_pkg::LW, 64'd8, 50, 10);
		next_cycle();
		dispatch_load(lsu_pkg::LD, 64'd16, 51, 30);
		next_cycle();
		repeat (2) next_cycle();
		dispatch_load(lsu_pkg::LH, 64'hffff_ffff_ffff_fffc, 52, 31);
		next_cycle();
		lu_exe_ready = 1'b0;
		write_back(30, 64'h0000_0000_0040_0000);
		next_cycle();
		write_back(31, 64'h0000_0000_0080_0000);
		next_cycle();
		next_cycle();
		drain_all();
		end_test();

		// Operand and commit gating, program order
		start_test("store_order");
		su_commit_ready = 1'b0;
		allocate_tag(40);
		next_cycle();
		dispatch_store(lsu_pkg::SD, 64'd32, 10, 40);
		next_cycle();
		dispatch_store(lsu_pkg::SB, 64'd1, 11, 12);
		next_cycle();
		repeat (3) next_cycle();
		write_back(40, 64'h0123_4567_89ab_cdef);
		next_cycle();
		repeat (3) next_cycle();
		su_commit_ready = 1'b1;
		allocate_tag(41);
		next_cycle();
		dispatch_store(lsu_pkg::SW, 64'd12, 41, 12);
		next_cycle();
		repeat (3) next_cycle();
		write_back(41, 64'h0000_0000_0010_0000);
		next_cycle();
		drain_all();
		end_test();

		// Stall with packets in flight on both sides
		start_test("back_pressure");
		dispatch_load(lsu_pkg::LBU, 64'd3, 60, 11);
		dispatch_store(lsu_pkg::SH, 64'd2, 12, 10);
		next_cycle();
		dispatch_load(lsu_pkg::LHU, 64'd5, 61, 12);
		dispatch_store(lsu_pkg::SW, 64'd4, 11, 12);
		next_cycle();
		lu_exe_ready = 1'b0;
		su_exe_ready = 1'b0;
		dispatch_load(lsu_pkg::LWU, 64'd7, 62, 10);
		next_cycle();
		repeat (6) next_cycle();
		lu_exe_ready = 1'b1;
		repeat (2) next_cycle();
		drain_all();
		end_test();

		// Four entries each, then a single issue
		start_test("full_buffers");
		lu_exe_ready = 1'b0;
		su_exe_ready = 1'b0;
		for (int i = 0; i < 4; i++) begin
			dispatch_load(lsu_pkg::LD, 64'(i * 8), PB'(70 + i), 10);
			dispatch_store(lsu_pkg::SD, 64'(i * 8), 11, 12);
			next_cycle();
		end
		a_full_set: assert (lu_full && su_full)
			else flag_error("full flags low with four entries buffered");
		lu_exe_ready = 1'b1;
		su_exe_ready = 1'b1;
		next_cycle();
		lu_exe_ready = 1'b0;
		su_exe_ready = 1'b0;
		a_full_clear: assert (!lu_full && !su_full)
			else flag_error("full flags still high after one accepted issue");
		repeat (3) next_cycle();
		drain_all();
		end_test();

		// Interleaved random traffic on the tag pool
		start_test("random_mix");
		for (int i = 32; i < 48; i++) begin
			write_back(PB'(i), {$random(seed), $random(seed)});
			next_cycle();
		end
		for (int c = 0; c < RANDOM_CYCLES; c++) begin
			lu_exe_ready = ($random(seed) & 3) != 0;
			su_exe_ready = ($random(seed) & 3) != 0;
			su_commit_ready = ($random(seed) & 1) != 0;
			if (($random(seed) & 3) == 0) begin
				tag = pool_tag();
				if (!tag_in_use(tag)) begin
					allocate_tag(tag);
					pending.push_back(tag);
				end
			end
			// May hit the tag renamed this cycle
			if (pending.size() > 0 && ($random(seed) & 3) == 0) begin
				idx = ($random(seed) & 32'h7fff_ffff) % pending.size();
				write_back(pending[idx], {$random(seed), $random(seed)});
				pending.delete(idx);
			end
			if (!lu_full && ($random(seed) & 1) != 0) begin
				dispatch_load(lsu_pkg::lu_op_e'(3'(($random(seed) & 32'h7fff_ffff) % 7)),
					{$random(seed), $random(seed)}, PB'($random(seed)), pool_tag());
			end
			if (!su_full && ($random(seed) & 1) != 0) begin
				dispatch_store(lsu_pkg::su_op_e'(2'($random(seed) & 3)),
					{$random(seed), $random(seed)}, pool_tag(), pool_tag());
			end
			next_cycle();
		end
		// Release every outstanding producer
		while (pending.size() > 0) begin
			write_back(pending.pop_front(), {$random(seed), $random(seed)});
			next_cycle();
		end
		drain_all();
		end_test();

		$display("Tests run %0d, errors %0d", tests_run, error_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// Ends a stuck run
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all tests finished");
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== filelist.f ====
verilog/core_cfg_pkg.sv
verilog/lsu_pkg.sv
verilog/phy_regfile.sv
verilog/lu_issue_buffer.sv
verilog/su_issue_fifo.sv
verilog/lsu_issue.sv
verilog/lsu_issue_top.sv
dv/lsu_issue_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = lsu_issue_tb
FILELIST = filelist.f
OBJ_DIR = obj_dir
PASS_MSG = Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
